//--- verilog/vjc_pkg.sv
// Shared widths, array field codes and the vertex byte swap function
`default_nettype none

package vjc_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// One vertex value or vertex id
	localparam int VERTEX_BITS = 32;

	// Vertices carried by one cacheline
	localparam int LINE_VERTICES = 4;

	localparam int LINE_BITS = VERTEX_BITS * LINE_VERTICES;

	localparam int ADDR_BITS = 64;

	// Address step from one batch to the next
	localparam int LINE_BYTES = 16;

	////////////////////////////////////////
	// Array field codes
	////////////////////////////////////////

	typedef enum logic [1:0] {
		FIELD_IN_DEGREE  = 2'd0,
		FIELD_OUT_DEGREE = 2'd1,
		FIELD_EDGES_IDX  = 2'd2
	} field_t;

	////////////////////////////////////////
	// Byte order
	////////////////////////////////////////

	// Memory words arrive big-endian, reverse the four bytes
	function automatic logic [VERTEX_BITS-1:0] swap_bytes(
		input logic [VERTEX_BITS-1:0] value
	);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

endpackage

`default_nettype wire

//--- verilog/read_cmd_if.sv
// Read command bus from the batch sequencer to the command queue
`default_nettype none

interface read_cmd_if;

	// One-cycle pulse per command
	logic valid;
	logic [vjc_pkg::ADDR_BITS-1:0] address;
	// Vertices requested by this command
	logic [vjc_pkg::VERTEX_BITS-1:0] count;
	vjc_pkg::field_t field;

	modport source (
		output valid,
		output address,
		output count,
		output field
	);

	modport sink (
		input valid,
		input address,
		input count,
		input field
	);

endinterface

`default_nettype wire

//--- verilog/sync_fifo.sv
// Synchronous circular FIFO with registered read data and full, alfull, empty flags
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  wire              clock,
	input  wire              rstn,
	input  wire              push,
	input  wire  [WIDTH-1:0] data_in,
	input  wire              pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	// Overflow and underflow requests are ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full   = (count == COUNT_BITS'(DEPTH));
	// One slot or fewer left
	assign alfull = (count >= COUNT_BITS'(DEPTH - 1));
	assign empty  = (count == '0);

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/cacheline_stream.sv
// Cacheline capture register that shifts one vertex value out per cycle
`default_nettype none

module cacheline_stream (
	input  wire                             clock,
	input  wire                             rstn,
	input  wire                             capture,
	input  wire  [vjc_pkg::LINE_BITS-1:0]   line_data,
	input  wire  [vjc_pkg::VERTEX_BITS-1:0] batch_count,
	input  wire                             shift,
	output logic [vjc_pkg::VERTEX_BITS-1:0] value,
	output logic                            valid,
	output logic                            pending
);

	localparam int VB = vjc_pkg::VERTEX_BITS;

	// Lowest-addressed vertex sits in the low word
	logic [vjc_pkg::LINE_BITS-1:0] line;
	logic [VB-1:0]                 left;
	logic                          step;

	assign step = shift && pending;

	always_ff @(posedge clock) begin
		if (capture) begin
			line <= line_data;
		end else if (step) begin
			line <= line >> VB;
		end
		if (step) begin
			value <= line[VB-1:0];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= 1'b0;
			valid   <= 1'b0;
			left    <= '0;
		end else begin
			valid <= step;
			if (capture) begin
				pending <= 1'b1;
				left    <= batch_count;
			end else if (step) begin
				left <= left - 1'b1;
				// Drop pending with the final value
				if (left == 1) begin
					pending <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/vertex_assembler.sv
// Vertex record assembly with numbering, byte swap and zero out-degree filter
`default_nettype none

module vertex_assembler (
	input  wire                               clock,
	input  wire                               rstn,
	input  wire  [vjc_pkg::VERTEX_BITS-1:0]   in_degree,
	input  wire  [vjc_pkg::VERTEX_BITS-1:0]   out_degree,
	input  wire  [vjc_pkg::VERTEX_BITS-1:0]   edges_idx,
	input  wire                               all_valid,
	output logic                              job_push,
	output logic [4*vjc_pkg::VERTEX_BITS-1:0] job_record,
	output logic [vjc_pkg::VERTEX_BITS-1:0]   filtered_count
);

	localparam int VB = vjc_pkg::VERTEX_BITS;

	logic          record_valid;
	logic [VB-1:0] next_id;
	logic [VB-1:0] record_id;
	logic [VB-1:0] record_in_degree;
	logic [VB-1:0] record_out_degree;
	logic [VB-1:0] record_edges_idx;
	logic          drop;

	////////////////////////////////////////
	// Record stage
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (all_valid) begin
			record_id         <= next_id;
			record_in_degree  <= vjc_pkg::swap_bytes(in_degree);
			record_out_degree <= vjc_pkg::swap_bytes(out_degree);
			record_edges_idx  <= vjc_pkg::swap_bytes(edges_idx);
		end
	end

	// Ids count every vertex, filtered ones included
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			record_valid <= 1'b0;
			next_id      <= '0;
		end else begin
			record_valid <= all_valid;
			if (all_valid) begin
				next_id <= next_id + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Filter stage
	////////////////////////////////////////

	// No outgoing edges means nothing to schedule
	assign drop     = record_valid && (record_out_degree == '0);
	assign job_push = record_valid && (record_out_degree != '0);

	assign job_record = {record_id, record_in_degree, record_out_degree, record_edges_idx};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			filtered_count <= '0;
		end else if (drop) begin
			filtered_count <= filtered_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/vertex_read_sequencer.sv
// Batch FSM issuing three array reads per batch and tracking outstanding lines
`default_nettype none

module vertex_read_sequencer (
	input  wire                             clock,
	input  wire                             rstn,
	input  wire                             start,
	input  wire  [vjc_pkg::VERTEX_BITS-1:0] num_vertices,
	input  wire  [vjc_pkg::ADDR_BITS-1:0]   base_in_degree,
	input  wire  [vjc_pkg::ADDR_BITS-1:0]   base_out_degree,
	input  wire  [vjc_pkg::ADDR_BITS-1:0]   base_edges_idx,
	input  wire                             line_valid,
	input  wire                             cmd_queue_empty,
	input  wire                             streams_pending,
	output logic                            responses_idle,
	output logic [vjc_pkg::VERTEX_BITS-1:0] batch_count,
	read_cmd_if.source                      cmd
);

	localparam int VB = vjc_pkg::VERTEX_BITS;
	localparam int AB = vjc_pkg::ADDR_BITS;

	localparam logic [VB-1:0] BATCH_MAX   = vjc_pkg::LINE_VERTICES;
	localparam logic [AB-1:0] OFFSET_STEP = vjc_pkg::LINE_BYTES;

	localparam logic [2:0] ST_RESET      = 3'd0;
	localparam logic [2:0] ST_INIT       = 3'd1;
	localparam logic [2:0] ST_WAIT       = 3'd2;
	localparam logic [2:0] ST_SIZE       = 3'd3;
	localparam logic [2:0] ST_IN_DEGREE  = 3'd4;
	localparam logic [2:0] ST_OUT_DEGREE = 3'd5;
	localparam logic [2:0] ST_EDGES_IDX  = 3'd6;

	logic [2:0]    state;
	logic [2:0]    next_state;
	logic [VB-1:0] remaining;
	logic [AB-1:0] offset;
	logic [AB-1:0] in_degree_base;
	logic [AB-1:0] out_degree_base;
	logic [AB-1:0] edges_idx_base;
	// At most three lines in flight per batch
	logic [3:0]    outstanding;
	logic          batch_ready;
	logic          issue;

	// Previous batch fully drained and work left
	assign batch_ready = cmd_queue_empty && !streams_pending && responses_idle
		&& (remaining != '0);

	always_comb begin
		next_state = state;
		case (state)
			ST_RESET:      if (start) next_state = ST_INIT;
			ST_INIT:       next_state = ST_WAIT;
			ST_WAIT:       if (batch_ready) next_state = ST_SIZE;
			ST_SIZE:       next_state = ST_IN_DEGREE;
			ST_IN_DEGREE:  next_state = ST_OUT_DEGREE;
			ST_OUT_DEGREE: next_state = ST_EDGES_IDX;
			ST_EDGES_IDX:  next_state = ST_WAIT;
			default:       next_state = ST_RESET;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= ST_RESET;
		end else begin
			state <= next_state;
		end
	end

	// Array bases held for the whole job
	always_ff @(posedge clock) begin
		if (state == ST_RESET && start) begin
			in_degree_base  <= base_in_degree;
			out_degree_base <= base_out_degree;
			edges_idx_base  <= base_edges_idx;
		end
	end

	////////////////////////////////////////
	// Batch bookkeeping
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining   <= '0;
			offset      <= '0;
			batch_count <= '0;
		end else begin
			case (state)
				ST_RESET: begin
					if (start) remaining <= num_vertices;
				end
				ST_INIT: begin
					offset      <= '0;
					batch_count <= '0;
				end
				ST_SIZE: begin
					if (remaining > BATCH_MAX) begin
						batch_count <= BATCH_MAX;
						remaining   <= remaining - BATCH_MAX;
					end else begin
						batch_count <= remaining;
						remaining   <= '0;
					end
				end
				// Last command of the batch moves to the next line
				ST_EDGES_IDX: offset <= offset + OFFSET_STEP;
				default: ;
			endcase
		end
	end

	always_comb begin
		issue       = 1'b0;
		cmd.address = in_degree_base + offset;
		cmd.field   = vjc_pkg::FIELD_IN_DEGREE;
		case (state)
			ST_IN_DEGREE: begin
				issue = 1'b1;
			end
			ST_OUT_DEGREE: begin
				issue       = 1'b1;
				cmd.address = out_degree_base + offset;
				cmd.field   = vjc_pkg::FIELD_OUT_DEGREE;
			end
			ST_EDGES_IDX: begin
				issue       = 1'b1;
				cmd.address = edges_idx_base + offset;
				cmd.field   = vjc_pkg::FIELD_EDGES_IDX;
			end
			default: ;
		endcase
	end

	assign cmd.valid = issue;
	assign cmd.count = batch_count;

	////////////////////////////////////////
	// Outstanding responses
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({issue, line_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				// both or neither leaves the count as is
				default: ;
			endcase
		end
	end

	assign responses_idle = (outstanding == '0);

endmodule

`default_nettype wire

//--- verilog/vertex_job_control.sv
// Vertex job control top level with command queue, streams, assembler and job queue
`default_nettype none

module vertex_job_control #(
	parameter int CMD_QUEUE_DEPTH = 8,
	parameter int JOB_QUEUE_DEPTH = 16
) (
	input  wire                                 clock,
	input  wire                                 rstn,
	input  wire                                 start,
	input  wire  [vjc_pkg::VERTEX_BITS-1:0]     num_vertices,
	input  wire  [vjc_pkg::ADDR_BITS-1:0]       base_in_degree,
	input  wire  [vjc_pkg::ADDR_BITS-1:0]       base_out_degree,
	input  wire  [vjc_pkg::ADDR_BITS-1:0]       base_edges_idx,
	input  wire                                 line_valid,
	input  wire  vjc_pkg::field_t               line_field,
	input  wire  [vjc_pkg::LINE_BITS-1:0]       line_data,
	input  wire                                 cmd_alfull,
	input  wire                                 vertex_request,
	output logic                                cmd_valid,
	output logic [vjc_pkg::ADDR_BITS-1:0]       cmd_address,
	output logic [vjc_pkg::VERTEX_BITS-1:0]     cmd_count,
	output vjc_pkg::field_t                     cmd_field,
	output logic                                job_empty,
	output logic [vjc_pkg::VERTEX_BITS-1:0]     job_id,
	output logic [vjc_pkg::VERTEX_BITS-1:0]     job_in_degree,
	output logic [vjc_pkg::VERTEX_BITS-1:0]     job_out_degree,
	output logic [vjc_pkg::VERTEX_BITS-1:0]     job_edges_idx,
	output logic [vjc_pkg::VERTEX_BITS-1:0]     filtered_count
);

	localparam int VB = vjc_pkg::VERTEX_BITS;
	localparam int AB = vjc_pkg::ADDR_BITS;
	// address, count, field
	localparam int CMD_BITS = AB + VB + 2;
	// id, in-degree, out-degree, edges index
	localparam int JOB_BITS = 4 * VB;

	read_cmd_if cmd_bus ();

	logic [VB-1:0]       batch_count;
	logic                responses_idle;
	logic                streams_pending;
	logic                shift;
	logic                cmd_queue_empty;
	logic                cmd_pop;
	logic [CMD_BITS-1:0] cmd_data;

	logic          capture_in_degree;
	logic          capture_out_degree;
	logic          capture_edges_idx;
	logic [VB-1:0] in_degree_value;
	logic [VB-1:0] out_degree_value;
	logic [VB-1:0] edges_idx_value;
	logic          in_degree_valid;
	logic          out_degree_valid;
	logic          edges_idx_valid;
	logic          in_degree_pending;
	logic          out_degree_pending;
	logic          edges_idx_pending;

	logic                job_push;
	logic [JOB_BITS-1:0] job_record;
	logic [JOB_BITS-1:0] job_data;

	////////////////////////////////////////
	// Read commands
	////////////////////////////////////////

	vertex_read_sequencer i_sequencer (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.base_in_degree  (base_in_degree),
		.base_out_degree (base_out_degree),
		.base_edges_idx  (base_edges_idx),
		.line_valid      (line_valid),
		.cmd_queue_empty (cmd_queue_empty),
		.streams_pending (streams_pending),
		.responses_idle  (responses_idle),
		.batch_count     (batch_count),
		.cmd             (cmd_bus.source)
	);

	// Nothing leaves the queue while the bus is almost full
	assign cmd_pop = !cmd_alfull && !cmd_queue_empty;

	sync_fifo #(
		.WIDTH (CMD_BITS),
		.DEPTH (CMD_QUEUE_DEPTH)
	) i_cmd_queue (
		.clock    (clock),
		.rstn     (rstn),
		.push     (cmd_bus.valid),
		.data_in  ({cmd_bus.address, cmd_bus.count, cmd_bus.field}),
		.pop      (cmd_pop),
		.data_out (cmd_data),
		.full     (),
		.alfull   (),
		.empty    (cmd_queue_empty)
	);

	// Queue output is already registered, valid follows the pop
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= cmd_pop;
		end
	end

	assign cmd_address = cmd_data[CMD_BITS-1 -: AB];
	assign cmd_count   = cmd_data[VB+1:2];
	assign cmd_field   = vjc_pkg::field_t'(cmd_data[1:0]);

	////////////////////////////////////////
	// Cacheline streams
	////////////////////////////////////////

	assign capture_in_degree  = line_valid && (line_field == vjc_pkg::FIELD_IN_DEGREE);
	assign capture_out_degree = line_valid && (line_field == vjc_pkg::FIELD_OUT_DEGREE);
	assign capture_edges_idx  = line_valid && (line_field == vjc_pkg::FIELD_EDGES_IDX);

	assign streams_pending = in_degree_pending || out_degree_pending || edges_idx_pending;
	// All lines are in once the response count is back to zero
	assign shift = streams_pending && responses_idle;

	cacheline_stream i_stream_in_degree (
		.clock       (clock),
		.rstn        (rstn),
		.capture     (capture_in_degree),
		.line_data   (line_data),
		.batch_count (batch_count),
		.shift       (shift),
		.value       (in_degree_value),
		.valid       (in_degree_valid),
		.pending     (in_degree_pending)
	);

	cacheline_stream i_stream_out_degree (
		.clock       (clock),
		.rstn        (rstn),
		.capture     (capture_out_degree),
		.line_data   (line_data),
		.batch_count (batch_count),
		.shift       (shift),
		.value       (out_degree_value),
		.valid       (out_degree_valid),
		.pending     (out_degree_pending)
	);

	cacheline_stream i_stream_edges_idx (
		.clock       (clock),
		.rstn        (rstn),
		.capture     (capture_edges_idx),
		.line_data   (line_data),
		.batch_count (batch_count),
		.shift       (shift),
		.value       (edges_idx_value),
		.valid       (edges_idx_valid),
		.pending     (edges_idx_pending)
	);

	////////////////////////////////////////
	// Vertex records and job queue
	////////////////////////////////////////

	vertex_assembler i_assembler (
		.clock          (clock),
		.rstn           (rstn),
		.in_degree      (in_degree_value),
		.out_degree     (out_degree_value),
		.edges_idx      (edges_idx_value),
		.all_valid      (in_degree_valid && out_degree_valid && edges_idx_valid),
		.job_push       (job_push),
		.job_record     (job_record),
		.filtered_count (filtered_count)
	);

	sync_fifo #(
		.WIDTH (JOB_BITS),
		.DEPTH (JOB_QUEUE_DEPTH)
	) i_job_queue (
		.clock    (clock),
		.rstn     (rstn),
		.push     (job_push),
		.data_in  (job_record),
		.pop      (vertex_request),
		.data_out (job_data),
		.full     (),
		.alfull   (),
		.empty    (job_empty)
	);

	assign job_id         = job_data[4*VB-1 -: VB];
	assign job_in_degree  = job_data[3*VB-1 -: VB];
	assign job_out_degree = job_data[2*VB-1 -: VB];
	assign job_edges_idx  = job_data[VB-1:0];

endmodule

`default_nettype wire

//--- tests/tb_vertex_job_control.sv
// Trace-driven testbench for vertex_job_control with a line memory model and job checks
`default_nettype none

module tb_vertex_job_control;

	localparam int TRACE_WORDS = 92;
	// Trace word where address 0 of the memory image sits
	localparam int MEM_WORD = 16;
	localparam int MEM_LAST = 63;
	localparam int JOB_WORD = 64;

	logic                  clock;
	logic                  rstn;
	logic                  start;
	logic [31:0]           num_vertices;
	logic [63:0]           base_in_degree;
	logic [63:0]           base_out_degree;
	logic [63:0]           base_edges_idx;
	logic                  line_valid;
	vjc_pkg::field_t       line_field;
	logic [127:0]          line_data;
	logic                  cmd_alfull;
	logic                  vertex_request;
	logic                  cmd_valid;
	logic [63:0]           cmd_address;
	logic [31:0]           cmd_count;
	vjc_pkg::field_t       cmd_field;
	logic                  job_empty;
	logic [31:0]           job_id;
	logic [31:0]           job_in_degree;
	logic [31:0]           job_out_degree;
	logic [31:0]           job_edges_idx;
	logic [31:0]           filtered_count;

	logic [31:0] trace_mem [0:TRACE_WORDS-1];
	logic [63:0] exp_addr [$];
	logic [31:0] exp_count [$];
	logic [1:0]  exp_field [$];
	logic [63:0] pend_addr [$];
	logic [1:0]  pend_field [$];
	int          cmds_seen = 0;
	int          lines_sent = 0;
	logic        alfull_last = 1'b0;

	vertex_job_control #(
		.CMD_QUEUE_DEPTH (8),
		.JOB_QUEUE_DEPTH (16)
	) i_dut (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.base_in_degree  (base_in_degree),
		.base_out_degree (base_out_degree),
		.base_edges_idx  (base_edges_idx),
		.line_valid      (line_valid),
		.line_field      (line_field),
		.line_data       (line_data),
		.cmd_alfull      (cmd_alfull),
		.vertex_request  (vertex_request),
		.cmd_valid       (cmd_valid),
		.cmd_address     (cmd_address),
		.cmd_count       (cmd_count),
		.cmd_field       (cmd_field),
		.job_empty       (job_empty),
		.job_id          (job_id),
		.job_in_degree   (job_in_degree),
		.job_out_degree  (job_out_degree),
		.job_edges_idx   (job_edges_idx),
		.filtered_count  (filtered_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic logic [63:0] array_base(input int field);
		return {trace_mem[1], trace_mem[2 + field]};
	endfunction

	// Three commands per batch, count capped at one line of vertices
	task automatic build_expected_commands();
		logic [31:0] left;
		logic [31:0] cnt;
		logic [63:0] offset;
		left = trace_mem[0];
		offset = '0;
		while (left != 0) begin
			cnt = (left < vjc_pkg::LINE_VERTICES) ? left : vjc_pkg::LINE_VERTICES;
			for (int f = 0; f < 3; f++) begin
				exp_addr.push_back(array_base(f) + offset);
				exp_count.push_back(cnt);
				exp_field.push_back(f[1:0]);
			end
			left = left - cnt;
			offset = offset + vjc_pkg::LINE_BYTES;
		end
	endtask

	task automatic check_reset_outputs();
		assert (cmd_valid == 1'b0)
			else abort_run($sformatf("mismatch cmd_valid: got %h expected 0", cmd_valid));
		assert (job_empty == 1'b1)
			else abort_run($sformatf("mismatch job_empty: got %h expected 1", job_empty));
		assert (filtered_count == '0)
			else abort_run($sformatf("mismatch filtered_count: got %h expected 0",
				filtered_count));
	endtask

	// Memory image holds big-endian words, lowest address in the low word
	task automatic read_line(input logic [63:0] address, output logic [127:0] data);
		int first;
		assert (address[63:32] == trace_mem[1] && address[3:0] == 4'h0)
			else abort_run("read address is not a cacheline inside the trace memory");
		first = MEM_WORD + int'(address[31:2]);
		assert (first + 3 <= MEM_LAST)
			else abort_run("read address runs past the end of the trace memory");
		data = {trace_mem[first+3], trace_mem[first+2], trace_mem[first+1], trace_mem[first]};
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp)
			else abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic pop_and_check_job(input int k);
		int word;
		int gap;
		word = JOB_WORD + 4 * k;
		gap = $urandom % 4;
		repeat (gap) @(negedge clock);
		assert (!job_empty)
			else abort_run("job_empty went high before the last job was popped");
		@(posedge clock);
		vertex_request <= 1'b1;
		@(posedge clock);
		vertex_request <= 1'b0;
		// Job fields are valid one cycle after the pop
		@(negedge clock);
		check_word("job_id", job_id, trace_mem[word]);
		check_word("job_in_degree", job_in_degree, trace_mem[word+1]);
		check_word("job_out_degree", job_out_degree, trace_mem[word+2]);
		check_word("job_edges_idx", job_edges_idx, trace_mem[word+3]);
	endtask

	////////////////////////////////////////
	// Command monitor and line responder
	////////////////////////////////////////

	initial begin : cmd_monitor
		forever begin
			@(negedge clock);
			if (rstn && cmd_valid) begin
				assert (!alfull_last)
					else abort_run("a command left the queue while cmd_alfull was high");
				assert (cmds_seen < exp_addr.size())
					else abort_run("more read commands than the vertex count needs");
				assert (cmd_address == exp_addr[cmds_seen])
					else abort_run($sformatf("mismatch cmd_address: got %h expected %h",
						cmd_address, exp_addr[cmds_seen]));
				check_word("cmd_count", cmd_count, exp_count[cmds_seen]);
				assert (cmd_field == exp_field[cmds_seen])
					else abort_run($sformatf("mismatch cmd_field: got %h expected %h",
						cmd_field, exp_field[cmds_seen]));
				pend_addr.push_back(cmd_address);
				pend_field.push_back(cmd_field);
				cmds_seen++;
			end
			alfull_last = cmd_alfull;
		end
	end

	// Answers pending commands in random order after random delays
	initial begin : line_responder
		int delay;
		int pick;
		logic [127:0] data;
		delay = 0;
		forever begin
			@(posedge clock);
			line_valid <= 1'b0;
			if (delay > 0) begin
				delay--;
			end else if (pend_addr.size() > 0) begin
				pick = $urandom % pend_addr.size();
				read_line(pend_addr[pick], data);
				line_valid <= 1'b1;
				line_field <= vjc_pkg::field_t'(pend_field[pick]);
				line_data  <= data;
				pend_addr.delete(pick);
				pend_field.delete(pick);
				lines_sent++;
				delay = 1 + $urandom % 5;
			end
		end
	end

	initial begin : alfull_driver
		int hold;
		hold = 0;
		forever begin
			@(posedge clock);
			if (start) begin
				// Long stall while the first batch queues up
				cmd_alfull <= 1'b1;
				hold = 20;
			end else if (hold > 0) begin
				hold--;
			end else if (cmd_alfull) begin
				cmd_alfull <= 1'b0;
				hold = 2 + $urandom % 10;
			end else begin
				cmd_alfull <= 1'b1;
				hold = $urandom % 5;
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin : main_sequence
		int timeout;
		void'($urandom(61));
		rstn            = 1'b0;
		start           = 1'b0;
		num_vertices    = '0;
		base_in_degree  = '0;
		base_out_degree = '0;
		base_edges_idx  = '0;
		line_valid      = 1'b0;
		line_field      = vjc_pkg::FIELD_IN_DEGREE;
		line_data       = '0;
		cmd_alfull      = 1'b0;
		vertex_request  = 1'b0;
		$readmemh("tests/vertex_trace.txt", trace_mem);
		build_expected_commands();

		repeat (5) @(negedge clock);
		check_reset_outputs();
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
		@(negedge clock);
		check_reset_outputs();

		@(posedge clock);
		start           <= 1'b1;
		num_vertices    <= trace_mem[0];
		base_in_degree  <= array_base(0);
		base_out_degree <= array_base(1);
		base_edges_idx  <= array_base(2);
		@(posedge clock);
		start <= 1'b0;

		// Requests are withheld until every line is back
		timeout = 0;
		while (lines_sent < exp_addr.size()) begin
			@(negedge clock);
			timeout++;
			assert (timeout < 2000) else abort_run("timed out waiting for all read responses");
		end
		// Final push lands batch count plus two cycles after the last line
		repeat (vjc_pkg::LINE_VERTICES + 6) @(negedge clock);
		check_word("filtered_count", filtered_count, trace_mem[6]);

		for (int k = 0; k < int'(trace_mem[5]); k++) begin
			pop_and_check_job(k);
		end

		if (job_empty) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run("job queue still holds jobs after the expected ones were popped");
		end
	end

endmodule

`default_nettype wire

//--- tests/vertex_trace.txt
// Header: vertex count, base high word, in/out/edges base low words, jobs, filtered
// @010/@020/@030 memory words (big-endian), @040 jobs: id, in, out, edges index
0000000A 00000002 00000000 00000040
00000080 00000007 00000003
@010
02000000 01000000 04000000 00000000
03000000 01000000 02000000 03020100
05000000 01800000 EE00000A EE00000B
EE00000C EE00000D EE00000E EE00000F
@020
03000000 00000000 01000000 02000000
00000000 05000000 01000000 23010000
00000000 07000000 EE01000A EE01000B
EE01000C EE01000D EE01000E EE01000F
@030
00000000 03000000 03000000 04000000
06000000 06000000 0B000000 0C000000
2F010000 2F010000 EE02000A EE02000B
EE02000C EE02000D EE02000E EE02000F
@040
00000000 00000002 00000003 00000000
00000002 00000004 00000001 00000003
00000003 00000000 00000002 00000004
00000005 00000001 00000005 00000006
00000006 00000002 00000001 0000000B
00000007 00010203 00000123 0000000C
00000009 00008001 00000007 0000012F

//--- compile.f
verilog/vjc_pkg.sv
verilog/read_cmd_if.sv
verilog/sync_fifo.sv
verilog/cacheline_stream.sv
verilog/vertex_assembler.sv
verilog/vertex_read_sequencer.sv
verilog/vertex_job_control.sv
tests/tb_vertex_job_control.sv
